//--- flist.f
hw/demux_pkg.sv
hw/id_fifo.sv
hw/addr_decoder.sv
hw/addr_demux.sv
hw/mem_bank.sv
hw/mem_subsystem.sv
tb/tb_mem_subsystem.sv

//--- tb/tb_mem_subsystem.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory subsystem testbench with
// shadow memory reference
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module tb_mem_subsystem
  import demux_pkg::*;
();

  localparam int NrBanks             = 4;
  localparam int NumRules            = 4;
  localparam int MaxOutstandingReads = 2;
  localparam int BankWords           = 256;
  localparam int IdxW                = $clog2(BankWords);
  localparam int NumRandReads        = 24;

  // writes and reads of every behavior together
  localparam int NumRequests   = 32 + 16 + 12 + NumRandReads + 4;
  localparam int TimeoutCycles = 4 * NumRequests + 200;

  logic                        clk_i;
  logic                        reset_i;
  address_map_t [NumRules-1:0] address_map_i;
  req_t                        req_i;
  logic                        req_valid_i;
  logic                        req_ready_o;
  resp_t                       resp_o;
  logic                        resp_valid_o;
  logic                        resp_ready_i;

  integer seed = 32'hdaff22aa;
  data_t  shadow [NrBanks][BankWords];
  data_t  exp_q[$];
  resp_t  exp_resp;
  int     cycle_cnt = 0;
  // 0 always ready, 1 random, 2 held low
  int     ready_mode = 0;
  logic [31:0] ready_bits;
  logic [31:0] rnd;
  data_t  wdata;
  int     rd_bank [NumRandReads];
  int     rd_word [NumRandReads];

  mem_subsystem #(
    .NrBanks             (NrBanks),
    .NumRules            (NumRules),
    .MaxOutstandingReads (MaxOutstandingReads),
    .BankWords           (BankWords)
  ) DUT (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .address_map_i (address_map_i),
    .req_i         (req_i),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .resp_o        (resp_o),
    .resp_valid_o  (resp_valid_o),
    .resp_ready_i  (resp_ready_i)
  );

  always #10 clk_i = ~clk_i;

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic check_resp(input string name, input resp_t got, input resp_t exp);
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH %s: got 0x%h expected 0x%h", name, got.rdata, exp.rdata));
    end
  endtask

  task automatic check_count(input string name, input int got, input int limit);
    if (got > limit) begin
      fail_run($sformatf("MISMATCH %s: got 0x%h above limit 0x%h", name, got, limit));
    end
  endtask

  // region i maps to bank 3-i in the default table
  function automatic address_map_t default_rule(input int i);
    address_map_t r;
    r.value    = addr_t'(i) << 12;
    r.mask     = 32'h3000;
    r.bank_idx = bank_idx_t'(3 - i);
    return r;
  endfunction

  function automatic addr_t bank_addr(input int bank, input int word);
    addr_t a;
    a = '0;
    a[13:12] = 2'(3 - bank);
    a[2 +: IdxW] = IdxW'(word);
    return a;
  endfunction

  // first matching rule wins and rule 0 takes what nothing matches
  function automatic bank_idx_t ref_bank(input addr_t a);
    bank_idx_t sel;
    bit        found;
    sel   = address_map_i[0].bank_idx;
    found = 1'b0;
    for (int i = 0; i < NumRules; i++) begin
      if (!found && ((a & address_map_i[i].mask) == address_map_i[i].value)) begin
        sel   = address_map_i[i].bank_idx;
        found = 1'b1;
      end
    end
    return sel;
  endfunction

  function automatic data_t ref_read(input addr_t a);
    return shadow[ref_bank(a)][a[2 +: IdxW]];
  endfunction

  function automatic void ref_write(input req_t r);
    bank_idx_t b;
    b = ref_bank(r.addr);
    for (int i = 0; i < 4; i++) begin
      if (r.be[i]) begin
        shadow[b][r.addr[2 +: IdxW]][8*i +: 8] = r.wdata[8*i +: 8];
      end
    end
  endfunction

  // holds valid until the edge where ready is seen
  task automatic send_req(input req_t r);
    req_i       <= r;
    req_valid_i <= 1'b1;
    @(posedge clk_i);
    while (!req_ready_o) @(posedge clk_i);
    req_valid_i <= 1'b0;
  endtask

  task automatic write_word(input addr_t a, input data_t d, input be_t be);
    send_req('{addr: a, write: 1'b1, wdata: d, be: be});
  endtask

  task automatic read_word(input addr_t a);
    send_req('{addr: a, write: 1'b0, wdata: '0, be: '0});
  endtask

  task automatic wait_idle();
    do @(posedge clk_i); while (exp_q.size() != 0);
  endtask

  // responses pop before new reads push
  always @(posedge clk_i) begin
    if (!reset_i) begin
      if (resp_valid_o && resp_ready_i) begin
        if (exp_q.size() == 0) begin
          fail_run("a response arrived with no read outstanding");
        end
        exp_resp.rdata = exp_q.pop_front();
        check_resp("resp_o", resp_o, exp_resp);
      end
      if (req_valid_i && req_ready_o) begin
        if (req_i.write) begin
          ref_write(req_i);
        end else begin
          exp_q.push_back(ref_read(req_i.addr));
        end
      end
      check_count("outstanding_reads", exp_q.size(), MaxOutstandingReads);
    end
  end

  always @(posedge clk_i) begin
    if (ready_mode == 1) begin
      ready_bits = $random(seed);
      resp_ready_i <= ready_bits[0];
    end else begin
      resp_ready_i <= (ready_mode == 0);
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TimeoutCycles) begin
      fail_run("the run timed out before all tests finished");
    end
  end

  initial begin
    clk_i        = 1'b0;
    reset_i      = 1'b1;
    req_i        = '0;
    req_valid_i  = 1'b0;
    resp_ready_i = 1'b1;
    for (int i = 0; i < NumRules; i++) begin
      address_map_i[i] = default_rule(i);
    end
    repeat (8) @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);

    // full-word writes to every bank, then read-back
    for (int b = 0; b < NrBanks; b++) begin
      for (int w = 0; w < 4; w++) begin
        wdata = $random(seed);
        write_word(bank_addr(b, w), wdata, 4'hf);
      end
    end
    for (int b = 0; b < NrBanks; b++) begin
      for (int w = 0; w < 4; w++) begin
        read_word(bank_addr(b, w));
      end
    end
    wait_idle();

    // partial writes keep the disabled bytes
    for (int i = 0; i < 8; i++) begin
      rnd   = $random(seed);
      wdata = $random(seed);
      write_word(bank_addr(rnd[1:0], rnd[3:2]), wdata, rnd[7:4]);
      read_word(bank_addr(rnd[1:0], rnd[3:2]));
    end
    wait_idle();

    // one value per region at the same offset
    for (int r = 0; r < 4; r++) begin
      write_word(bank_addr(3 - r, 16), 32'h5a00_0000 + r, 4'hf);
    end
    for (int r = 0; r < 4; r++) begin
      read_word(bank_addr(3 - r, 16));
    end
    wait_idle();
    // rule 1 now overlaps rules 0 and 2 and leaves region 1 unmatched
    address_map_i[1] <= '{value: 32'h0, mask: 32'h1000, bank_idx: 2'd2};
    @(posedge clk_i);
    for (int r = 0; r < 4; r++) begin
      read_word(bank_addr(3 - r, 16));
    end
    wait_idle();
    address_map_i[1] <= default_rule(1);
    @(posedge clk_i);

    // random reads under random back-pressure
    for (int i = 0; i < NumRandReads; i++) begin
      rnd        = $random(seed);
      rd_bank[i] = rnd[1:0];
      rd_word[i] = rnd[3:2];
    end
    ready_mode <= 1;
    for (int i = 0; i < NumRandReads; i++) begin
      read_word(bank_addr(rd_bank[i], rd_word[i]));
    end
    ready_mode <= 0;
    wait_idle();

    // fill the id fifo with the core stalled and push a write past it
    ready_mode <= 2;
    @(posedge clk_i);
    read_word(bank_addr(0, 0));
    read_word(bank_addr(1, 0));
    req_i       <= '{addr: bank_addr(2, 32), write: 1'b1, wdata: 32'hc0de_f00d, be: 4'hf};
    req_valid_i <= 1'b1;
    @(posedge clk_i);
    for (int i = 0; i < 4 && !req_ready_o; i++) @(posedge clk_i);
    if (!req_ready_o) begin
      fail_run("a write to an idle bank stalled while the read FIFO was full");
    end
    req_valid_i <= 1'b0;
    ready_mode  <= 0;
    wait_idle();
    read_word(bank_addr(2, 32));
    wait_idle();

    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- hw/mem_subsystem.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory subsystem top, demux
// in front of the banks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module mem_subsystem
  import demux_pkg::*;
#(
  parameter int unsigned NrBanks             = 4,
  parameter int unsigned NumRules            = 4,
  parameter int unsigned MaxOutstandingReads = 2,
  parameter int unsigned BankWords           = 256
) (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  address_map_t [NumRules-1:0] address_map_i,
  input  req_t                        req_i,
  input  logic                        req_valid_i,
  output logic                        req_ready_o,
  output resp_t                       resp_o,
  output logic                        resp_valid_o,
  input  logic                        resp_ready_i
);

  req_t                bank_req;
  logic  [NrBanks-1:0] bank_req_valid;
  logic  [NrBanks-1:0] bank_req_ready;
  resp_t [NrBanks-1:0] bank_resp;
  logic  [NrBanks-1:0] bank_resp_valid;
  logic  [NrBanks-1:0] bank_resp_ready;

  addr_demux #(
    .NrBanks             (NrBanks),
    .NumRules            (NumRules),
    .MaxOutstandingReads (MaxOutstandingReads)
  ) i_addr_demux (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .address_map_i     (address_map_i),
    .req_i             (req_i),
    .req_valid_i       (req_valid_i),
    .req_ready_o       (req_ready_o),
    .resp_o            (resp_o),
    .resp_valid_o      (resp_valid_o),
    .resp_ready_i      (resp_ready_i),
    .bank_req_o        (bank_req),
    .bank_req_valid_o  (bank_req_valid),
    .bank_req_ready_i  (bank_req_ready),
    .bank_resp_i       (bank_resp),
    .bank_resp_valid_i (bank_resp_valid),
    .bank_resp_ready_o (bank_resp_ready)
  );

  // identical banks, all see the same request payload
  for (genvar i = 0; i < NrBanks; i++) begin : gen_banks
    mem_bank #(
      .BankWords (BankWords)
    ) i_mem_bank (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .req_i        (bank_req),
      .req_valid_i  (bank_req_valid[i]),
      .req_ready_o  (bank_req_ready[i]),
      .resp_o       (bank_resp[i]),
      .resp_valid_o (bank_resp_valid[i]),
      .resp_ready_i (bank_resp_ready[i])
    );
  end

endmodule

//--- hw/mem_bank.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory bank with byte enables
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module mem_bank
  import demux_pkg::*;
#(
  parameter int unsigned BankWords = 256
) (
  input  logic  clk_i,
  input  logic  reset_i,
  input  req_t  req_i,
  input  logic  req_valid_i,
  output logic  req_ready_o,
  output resp_t resp_o,
  output logic  resp_valid_o,
  input  logic  resp_ready_i
);

  localparam int unsigned NumBytes = $bits(data_t) / 8;
  localparam int unsigned OffW     = $clog2(NumBytes);
  localparam int unsigned IdxW     = $clog2(BankWords);

  data_t           mem_q [BankWords];
  logic [IdxW-1:0] word_idx;
  logic            rd_fire;
  logic            wr_fire;
  resp_t           resp_q;
  logic            resp_valid_q;

  // word index sits right above the byte offset
  assign word_idx = req_i.addr[OffW +: IdxW];

  // a held response blocks reads only, writes always go through
  assign req_ready_o = req_i.write | ~resp_valid_q | resp_ready_i;

  assign rd_fire = req_valid_i & req_ready_o & ~req_i.write;
  assign wr_fire = req_valid_i & req_ready_o & req_i.write;

  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      for (int b = 0; b < NumBytes; b++) begin
        if (req_i.be[b]) begin
          mem_q[word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
    if (rd_fire) begin
      resp_q.rdata <= mem_q[word_idx];
    end
  end

  // new read wins over a drain in the same cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_valid_q <= 1'b0;
    end else if (rd_fire) begin
      resp_valid_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  assign resp_o       = resp_q;
  assign resp_valid_o = resp_valid_q;

  assert property (@(posedge clk_i) disable iff (reset_i)
    (resp_valid_o && !resp_ready_i) |=> (resp_valid_o && $stable(resp_o)))
    else $error("bank response changed before it was drained");

endmodule

//--- hw/addr_demux.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// address demux that routes to banks
// and returns reads in order
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module addr_demux
  import demux_pkg::*;
#(
  parameter int unsigned NrBanks             = 4,
  parameter int unsigned NumRules            = 4,
  parameter int unsigned MaxOutstandingReads = 2
) (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  address_map_t [NumRules-1:0] address_map_i,
  // core side
  input  req_t                        req_i,
  input  logic                        req_valid_i,
  output logic                        req_ready_o,
  output resp_t                       resp_o,
  output logic                        resp_valid_o,
  input  logic                        resp_ready_i,
  // bank side
  output req_t                        bank_req_o,
  output logic         [NrBanks-1:0]  bank_req_valid_o,
  input  logic         [NrBanks-1:0]  bank_req_ready_i,
  input  resp_t        [NrBanks-1:0]  bank_resp_i,
  input  logic         [NrBanks-1:0]  bank_resp_valid_i,
  output logic         [NrBanks-1:0]  bank_resp_ready_o
);

  bank_idx_t          bank_sel;
  logic [NrBanks-1:0] bank_onehot;
  logic [NrBanks-1:0] id_head;
  logic [NrBanks-1:0] head_sel;
  logic               id_full;
  logic               id_empty;
  logic               read_ok;
  logic               push_id;
  logic               pop_id;

  addr_decoder #(
    .NumRules (NumRules)
  ) i_addr_decoder (
    .address_map_i (address_map_i),
    .addr_i        (req_i.addr),
    .bank_sel_o    (bank_sel)
  );

  // select outside the bank range leaves every valid low
  always_comb begin
    for (int i = 0; i < NrBanks; i++) begin
      bank_onehot[i] = (bank_sel == bank_idx_t'(i));
    end
  end

  // reads need a free slot in the id fifo but writes never wait on it
  assign read_ok = req_i.write | ~id_full;

  assign bank_req_o       = req_i;
  assign bank_req_valid_o = bank_onehot & {NrBanks{req_valid_i & read_ok}};
  assign req_ready_o      = read_ok & |(bank_onehot & bank_req_ready_i);

  assign push_id = req_valid_i & req_ready_o & ~req_i.write;
  assign pop_id  = resp_valid_o & resp_ready_i;

  id_fifo #(
    .Depth (MaxOutstandingReads),
    .Width (NrBanks)
  ) i_id_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .push_i  (push_id),
    .pop_i   (pop_id),
    .data_i  (bank_onehot),
    .data_o  (id_head),
    .full_o  (id_full),
    .empty_o (id_empty)
  );

  // mask the head while empty since fifo storage is not reset
  assign head_sel = id_empty ? '0 : id_head;

  // only the bank that owes the oldest read is visible
  always_comb begin
    resp_o       = '0;
    resp_valid_o = 1'b0;
    for (int i = 0; i < NrBanks; i++) begin
      if (head_sel[i]) begin
        resp_o       = bank_resp_i[i];
        resp_valid_o = bank_resp_valid_i[i];
      end
    end
  end

  assign bank_resp_ready_o = head_sel & {NrBanks{resp_ready_i}};

  // the bank takes an accepted request in the same cycle
  assert property (@(posedge clk_i) disable iff (reset_i)
    (req_valid_i && req_ready_o) |-> |(bank_req_valid_o & bank_req_ready_i))
    else $error("accepted request not taken by any bank");

  assert property (@(posedge clk_i) disable iff (reset_i) push_id |-> !id_full)
    else $error("id fifo push while full");

  // an accepted write leaves the fifo occupancy alone
  assert property (@(posedge clk_i) disable iff (reset_i)
    (req_valid_i && req_ready_o && req_i.write && !pop_id)
      |=> ($stable(id_full) && $stable(id_empty)))
    else $error("id fifo occupancy changed by a write");

  assert property (@(posedge clk_i) disable iff (reset_i) pop_id |-> !id_empty)
    else $error("id fifo pop while empty");

endmodule

//--- hw/addr_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// address rule table decoder
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module addr_decoder
  import demux_pkg::*;
#(
  parameter int unsigned NumRules = 4
) (
  input  address_map_t [NumRules-1:0] address_map_i,
  input  addr_t                       addr_i,
  output bank_idx_t                   bank_sel_o
);

  logic [NumRules-1:0] addr_match;

  // one compare per rule
  always_comb begin
    for (int i = 0; i < NumRules; i++) begin
      addr_match[i] = ((addr_i & address_map_i[i].mask) == address_map_i[i].value);
    end
  end

  // walk from the top down so the lowest matching rule wins,
  // rule 0 is the fallback when nothing matches
  always_comb begin
    bank_sel_o = address_map_i[0].bank_idx;
    for (int i = NumRules - 1; i >= 0; i--) begin
      if (addr_match[i]) begin
        bank_sel_o = address_map_i[i].bank_idx;
      end
    end
  end

endmodule

//--- hw/id_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// id fifo, bank select per
// outstanding read
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module id_fifo #(
  parameter int unsigned Depth = 2,
  parameter int unsigned Width = 4
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             push_i,
  input  logic             pop_i,
  input  logic [Width-1:0] data_i,
  output logic [Width-1:0] data_o,
  output logic             full_o,
  output logic             empty_o
);

  // a depth of one still needs a one-bit pointer
  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  logic [Width-1:0] mem_q [Depth];
  logic [PtrW-1:0]  wr_ptr_q;
  logic [PtrW-1:0]  rd_ptr_q;
  logic [CntW-1:0]  count_q;

  assign full_o  = (count_q == CntW'(Depth));
  assign empty_o = (count_q == '0);
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop keeps the count
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // storage only
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // a push into a full fifo is only legal together with a pop
  assert property (@(posedge clk_i) disable iff (reset_i)
    !(push_i && full_o && !pop_i) && !(pop_i && empty_o))
    else $error("id_fifo overflow or underflow");

endmodule

//--- hw/demux_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory subsystem shared types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package demux_pkg;

  // byte address of a core request
  typedef logic [31:0] addr_t;

  // one data word
  typedef logic [31:0] data_t;

  // one enable bit per byte of data_t
  typedef logic [3:0] be_t;

  // bank number, so at most 4 banks
  typedef logic [1:0] bank_idx_t;

  // core request, broadcast unchanged to every bank
  typedef struct packed {
    addr_t addr;
    logic  write;
    data_t wdata;
    be_t   be;
  } req_t;

  // read response, writes return nothing
  typedef struct packed {
    data_t rdata;
  } resp_t;

  // a rule hits when (addr & mask) == value
  typedef struct packed {
    addr_t     value;
    addr_t     mask;
    bank_idx_t bank_idx;
  } address_map_t;

endpackage
